// ==== hw/idx_addr_calc.sv ====
/*
  combinational effective address and index writeback value
  all sums wrap at the address width, 8-bit offsets are sign extended
*/
`timescale 1ns/1ps

module idx_addr_calc (
    input  idx_mode_pkg::idx_mode_t        mode,
    input  logic [idx_bus_pkg::addr_w-1:0] base,
    input  logic [idx_bus_pkg::data_w-1:0] acc_a,
    input  logic [idx_bus_pkg::data_w-1:0] acc_b,
    input  logic [idx_bus_pkg::addr_w-1:0] offset,
    input  logic [idx_bus_pkg::addr_w-1:0] next_pc,
    output logic [idx_bus_pkg::addr_w-1:0] ea,
    output logic [idx_bus_pkg::addr_w-1:0] wb_value,
    output logic                           wb_en
);
    import idx_bus_pkg::*;
    import idx_mode_pkg::*;

    logic [addr_w-1:0] base_val;  // index reg, next_pc or zero
    logic [addr_w-1:0] ea_off;    // offset added to base_val
    logic [addr_w-1:0] step;      // inc/dec amount
    logic              pre_dec;   // ea takes the decremented value

    function automatic logic [addr_w-1:0] sext(input logic [data_w-1:0] v);
        return {{(addr_w-data_w){v[data_w-1]}}, v};
    endfunction

    // --------------------------------------------------
    // offset and base selection
    // --------------------------------------------------
    // accumulator modes use scoped names, the ports shadow the enum values
    always_comb begin
        base_val = base;
        ea_off   = '0;
        step     = '0;
        pre_dec  = 1'b0;
        wb_en    = 1'b0;
        case (mode)
            inc1:   begin step = addr_w'(1); wb_en = 1'b1; end
            inc2:   begin step = addr_w'(2); wb_en = 1'b1; end
            dec1:   begin step = addr_w'(1); wb_en = 1'b1; pre_dec = 1'b1; end
            dec2:   begin step = addr_w'(2); wb_en = 1'b1; pre_dec = 1'b1; end
            idx_mode_pkg::acc_b: ea_off = sext(acc_b);
            idx_mode_pkg::acc_a: ea_off = sext(acc_a);
            acc_d:  ea_off = {acc_a, acc_b};
            off8:   ea_off = sext(offset[data_w-1:0]);
            off16:  ea_off = offset;
            // pc relative, next_pc already points past the offset bytes
            pc8:    begin base_val = next_pc; ea_off = sext(offset[data_w-1:0]); end
            pc16:   begin base_val = next_pc; ea_off = offset; end
            // absolute word, no base
            extended: begin base_val = '0; ea_off = offset; end
            default: ;  // zero offset
        endcase
    end

    // --------------------------------------------------
    // results
    // --------------------------------------------------
    // post-increment: ea is the old value, pre-decrement: ea is the new one
    assign wb_value = pre_dec ? base - step : base + step;
    assign ea       = pre_dec ? wb_value : base_val + ea_off;

endmodule

// ==== hw/idx_bus_pkg.sv ====
/*
  bus widths and sequencer states, shared by the RTL and the bound checks
*/
package idx_bus_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    // addresses and index registers
    localparam int addr_w = 16;
    // one memory byte, also the accumulator width
    localparam int data_w = 8;

    // --------------------------------------------------
    // sequencer states
    // --------------------------------------------------
    // each fetch state spans a strobe phase and a capture phase
    typedef enum logic [2:0] {
        idle,
        fetch_post,
        fetch_off_hi,
        fetch_off_lo,
        fetch_ind_hi,
        fetch_ind_lo,
        finish
    } seq_state_t;

endpackage

// ==== hw/idx_mode_pkg.sv ====
/*
  postbyte layout and indexed mode encodings for the 6809 style indexed unit
  undefined mode codes are folded into zero mode by the decoder
*/
package idx_mode_pkg;

    // --------------------------------------------------
    // postbyte field positions
    // --------------------------------------------------
    // bit 7 selects the long form, bit 3 the indirect form
    localparam int pb_long_bit = 7;
    localparam int pb_ind_bit  = 3;
    // index register field
    localparam int pb_reg_hi   = 6;
    localparam int pb_reg_lo   = 5;
    // low mode code, joined with the long bit
    localparam int pb_code_hi  = 2;
    localparam int pb_code_lo  = 0;

    // --------------------------------------------------
    // offset modes
    // --------------------------------------------------
    // encoded as {long bit, bits 2:0} so the decode table reads directly
    typedef enum logic [3:0] {
        inc1     = 4'b0_000,
        inc2     = 4'b0_001,
        dec1     = 4'b0_010,
        dec2     = 4'b0_011,
        zero     = 4'b0_100,
        acc_b    = 4'b0_101,
        acc_a    = 4'b0_110,
        off8     = 4'b1_000,
        off16    = 4'b1_001,
        acc_d    = 4'b1_011,
        pc8      = 4'b1_100,
        pc16     = 4'b1_101,
        extended = 4'b1_111
    } idx_mode_t;

    // index register named by postbyte bits 6:5
    typedef enum logic [1:0] {
        reg_x = 2'd0,
        reg_y = 2'd1,
        reg_u = 2'd2,
        reg_s = 2'd3
    } idx_reg_t;

    // external register port select
    typedef enum logic [2:0] {
        sel_a, sel_b, sel_x, sel_y, sel_u, sel_s
    } reg_sel_t;

endpackage

// ==== hw/idx_postbyte_decode.sv ====
/*
  pure decode of an indexed postbyte, no state
  codes missing from the mode table decode as zero offset
*/
`timescale 1ns/1ps

module idx_postbyte_decode (
    input  logic [idx_bus_pkg::data_w-1:0] postbyte,
    output idx_mode_pkg::idx_mode_t        mode,
    output idx_mode_pkg::idx_reg_t         rsel,
    output logic                           indirect,
    output logic [1:0]                     off_bytes
);
    import idx_mode_pkg::*;

    // long bit joined with the low three bits
    logic [3:0] code;

    assign code = {postbyte[pb_long_bit], postbyte[pb_code_hi:pb_code_lo]};

    // --------------------------------------------------
    // mode code
    // --------------------------------------------------
    always_comb begin
        case (code)
            4'b0_000: mode = inc1;
            4'b0_001: mode = inc2;
            4'b0_010: mode = dec1;
            4'b0_011: mode = dec2;
            4'b0_100: mode = zero;
            4'b0_101: mode = acc_b;
            4'b0_110: mode = acc_a;
            4'b1_000: mode = off8;
            4'b1_001: mode = off16;
            4'b1_011: mode = acc_d;
            4'b1_100: mode = pc8;
            4'b1_101: mode = pc16;
            4'b1_111: mode = extended;
            // 0_111, 1_010, 1_110 are undefined
            default:  mode = zero;
        endcase
    end

    // --------------------------------------------------
    // register field and indirect flag
    // --------------------------------------------------
    // extended ignores the register field, the value is still passed on
    assign rsel     = idx_reg_t'(postbyte[pb_reg_hi:pb_reg_lo]);
    assign indirect = postbyte[pb_ind_bit];

    // --------------------------------------------------
    // bytes that follow the postbyte
    // --------------------------------------------------
    always_comb begin
        case (mode)
            // one signed displacement byte
            off8, pc8: begin
                off_bytes = 2'd1;
            end
            // big-endian word
            off16, pc16, extended: begin
                off_bytes = 2'd2;
            end
            // constant and accumulator offsets need no fetch
            default: begin
                off_bytes = 2'd0;
            end
        endcase
    end

endmodule

// ==== hw/idx_regs.sv ====
/*
  accumulators A, B and index registers X, Y, U, S
  a writeback to the same register as an external write takes priority
*/
`timescale 1ns/1ps

module idx_regs (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           reg_wr,
    input  idx_mode_pkg::reg_sel_t         reg_sel,
    input  logic [idx_bus_pkg::addr_w-1:0] reg_wdata,
    output logic [idx_bus_pkg::addr_w-1:0] reg_rdata,
    input  idx_mode_pkg::idx_reg_t         rsel,
    input  logic                           idx_wb,
    input  logic [idx_bus_pkg::addr_w-1:0] wb_value,
    output logic [idx_bus_pkg::addr_w-1:0] base,
    output logic [idx_bus_pkg::data_w-1:0] acc_a,
    output logic [idx_bus_pkg::data_w-1:0] acc_b
);
    import idx_bus_pkg::*;
    import idx_mode_pkg::*;

    logic [data_w-1:0] a_q, b_q;
    logic [addr_w-1:0] x_q, y_q, u_q, s_q;

    // external port first, writeback last so it overrides
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_q <= '0;
            b_q <= '0;
            x_q <= '0;
            y_q <= '0;
            u_q <= '0;
            s_q <= '0;
        end else begin
            if (reg_wr) begin
                case (reg_sel)
                    sel_a:   a_q <= reg_wdata[data_w-1:0];
                    sel_b:   b_q <= reg_wdata[data_w-1:0];
                    sel_x:   x_q <= reg_wdata;
                    sel_y:   y_q <= reg_wdata;
                    sel_u:   u_q <= reg_wdata;
                    sel_s:   s_q <= reg_wdata;
                    default: ;
                endcase
            end
            if (idx_wb) begin
                case (rsel)
                    reg_x: x_q <= wb_value;
                    reg_y: y_q <= wb_value;
                    reg_u: u_q <= wb_value;
                    reg_s: s_q <= wb_value;
                endcase
            end
        end
    end

    // --------------------------------------------------
    // read side
    // --------------------------------------------------
    assign acc_a = a_q;
    assign acc_b = b_q;

    always_comb begin
        case (rsel)
            reg_x: base = x_q;
            reg_y: base = y_q;
            reg_u: base = u_q;
            reg_s: base = s_q;
        endcase
    end

    // accumulators read back zero extended
    always_comb begin
        case (reg_sel)
            sel_a:   reg_rdata = {{(addr_w-data_w){1'b0}}, a_q};
            sel_b:   reg_rdata = {{(addr_w-data_w){1'b0}}, b_q};
            sel_x:   reg_rdata = x_q;
            sel_y:   reg_rdata = y_q;
            sel_u:   reg_rdata = u_q;
            sel_s:   reg_rdata = s_q;
            default: reg_rdata = '0;
        endcase
    end

endmodule

// ==== hw/idx_sequencer.sv ====
/*
  fetch sequencer, two cen cycles per byte (strobe, then capture)
  memory data must be valid on the cen cycle after mem_rd, start is ignored while busy
*/
`timescale 1ns/1ps

module idx_sequencer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cen,
    input  logic                           start,
    input  logic [idx_bus_pkg::addr_w-1:0] pc,
    output logic [idx_bus_pkg::addr_w-1:0] mem_addr,
    output logic                           mem_rd,
    input  logic [idx_bus_pkg::data_w-1:0] mem_rdata,
    output logic [idx_bus_pkg::data_w-1:0] postbyte,
    input  logic [1:0]                     off_bytes,
    input  logic                           indirect,
    input  logic [idx_bus_pkg::addr_w-1:0] calc_ea,
    input  logic                           wb_en,
    output logic [idx_bus_pkg::addr_w-1:0] offset,
    output logic [idx_bus_pkg::addr_w-1:0] next_pc,
    output logic                           idx_wb,
    output logic [idx_bus_pkg::addr_w-1:0] ea,
    output logic                           busy,
    output logic                           done
);
    import idx_bus_pkg::*;

    seq_state_t        state;
    seq_state_t        after_off;  // state once offset bytes are in
    logic              phase;      // 0 strobe, 1 capture
    logic              fetching;
    logic              capture;
    logic [addr_w-1:0] ptr;        // fetch pointer, walks from pc
    logic [data_w-1:0] pb_q;
    logic [addr_w-1:0] ind_word;

    assign fetching  = state inside {fetch_post, fetch_off_hi, fetch_off_lo,
                                     fetch_ind_hi, fetch_ind_lo};
    assign capture   = fetching && phase;
    assign mem_rd    = fetching && !phase;
    assign busy      = state != idle;
    assign next_pc   = ptr;
    assign after_off = indirect ? fetch_ind_hi : finish;

    // indirect word is read from the computed address, big-endian
    assign mem_addr = (state == fetch_ind_hi) ? calc_ea :
                      (state == fetch_ind_lo) ? calc_ea + 1'b1 : ptr;

    // bypass so the decode of a new postbyte steers the very next state
    assign postbyte = (state == fetch_post && phase) ? mem_rdata : pb_q;

    // single pulse, index regs have no cen of their own
    assign idx_wb = cen && (state == finish) && wb_en;

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
            phase <= 1'b0;
            ptr   <= '0;
            done  <= 1'b0;
        end else if (cen) begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        ptr   <= pc;
                        phase <= 1'b0;
                        state <= fetch_post;
                    end
                end
                finish: begin
                    done  <= 1'b1;
                    state <= idle;
                end
                default: begin
                    phase <= ~phase;
                    if (phase) begin
                        case (state)
                            fetch_post: begin
                                ptr <= ptr + 1'b1;
                                case (off_bytes)
                                    2'd2:    state <= fetch_off_hi;
                                    2'd1:    state <= fetch_off_lo;
                                    default: state <= after_off;
                                endcase
                            end
                            fetch_off_hi: begin
                                ptr   <= ptr + 1'b1;
                                state <= fetch_off_lo;
                            end
                            fetch_off_lo: begin
                                ptr   <= ptr + 1'b1;
                                state <= after_off;
                            end
                            fetch_ind_hi: state <= fetch_ind_lo;
                            default:      state <= finish;
                        endcase
                    end
                end
            endcase
        end
    end

    // --------------------------------------------------
    // captured bytes and result
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (cen) begin
            // one byte offsets only use the low half
            if (state == idle && start) offset <= '0;
            if (capture) begin
                case (state)
                    fetch_post:   pb_q                    <= mem_rdata;
                    fetch_off_hi: offset[addr_w-1:data_w] <= mem_rdata;
                    fetch_off_lo: offset[data_w-1:0]      <= mem_rdata;
                    fetch_ind_hi: ind_word[addr_w-1:data_w] <= mem_rdata;
                    default:      ind_word[data_w-1:0]    <= mem_rdata;
                endcase
            end
            if (state == finish) ea <= indirect ? ind_word : calc_ea;
        end
    end

endmodule

// ==== hw/idx_unit.sv ====
/*
  indexed addressing unit top, memory is a byte read port with one cen cycle latency
*/
`timescale 1ns/1ps

module idx_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cen,
    // control
    input  logic                           start,
    input  logic [idx_bus_pkg::addr_w-1:0] pc,
    // memory read port
    output logic [idx_bus_pkg::addr_w-1:0] mem_addr,
    output logic                           mem_rd,
    input  logic [idx_bus_pkg::data_w-1:0] mem_rdata,
    // register port
    input  logic                           reg_wr,
    input  idx_mode_pkg::reg_sel_t         reg_sel,
    input  logic [idx_bus_pkg::addr_w-1:0] reg_wdata,
    output logic [idx_bus_pkg::addr_w-1:0] reg_rdata,
    // result
    output logic [idx_bus_pkg::addr_w-1:0] ea,
    output logic                           done,
    output logic                           busy
);
    import idx_bus_pkg::*;
    import idx_mode_pkg::*;

    logic [data_w-1:0] postbyte;
    idx_mode_t         mode;
    idx_reg_t          rsel;
    logic              indirect;
    logic [1:0]        off_bytes;
    logic [addr_w-1:0] base, offset, next_pc, calc_ea, wb_value;
    logic [data_w-1:0] acc_a, acc_b;
    logic              wb_en, idx_wb;

    idx_postbyte_decode decode_inst (
        .postbyte(postbyte), .mode(mode), .rsel(rsel),
        .indirect(indirect), .off_bytes(off_bytes)
    );

    idx_addr_calc calc_inst (
        .mode(mode), .base(base), .acc_a(acc_a), .acc_b(acc_b),
        .offset(offset), .next_pc(next_pc),
        .ea(calc_ea), .wb_value(wb_value), .wb_en(wb_en)
    );

    idx_regs regs_inst (
        .clk(clk), .rst(rst),
        .reg_wr(reg_wr), .reg_sel(reg_sel), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .rsel(rsel), .idx_wb(idx_wb), .wb_value(wb_value),
        .base(base), .acc_a(acc_a), .acc_b(acc_b)
    );

    idx_sequencer seq_inst (
        .clk(clk), .rst(rst), .cen(cen), .start(start), .pc(pc),
        .mem_addr(mem_addr), .mem_rd(mem_rd), .mem_rdata(mem_rdata),
        .postbyte(postbyte), .off_bytes(off_bytes), .indirect(indirect),
        .calc_ea(calc_ea), .wb_en(wb_en), .offset(offset), .next_pc(next_pc),
        .idx_wb(idx_wb), .ea(ea), .busy(busy), .done(done)
    );

endmodule

// ==== idx_unit.f ====
hw/idx_bus_pkg.sv
hw/idx_mode_pkg.sv
hw/idx_postbyte_decode.sv
hw/idx_addr_calc.sv
hw/idx_regs.sv
hw/idx_sequencer.sv
hw/idx_unit.sv
tb/idx_unit_assertions.sv
tb/idx_unit_tb.sv

// ==== tb/idx_unit_assertions.sv ====
/*
  concurrent checks bound into idx_sequencer, sampled on clk, idle during reset
*/
`timescale 1ns/1ps

module idx_unit_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    cen,
    input idx_bus_pkg::seq_state_t state,
    input logic                    mem_rd,
    input logic                    busy,
    input logic                    done
);
    import idx_bus_pkg::*;

    // --------------------------------------------------
    // strobe relations
    // --------------------------------------------------
    // a read strobe never overlaps the completion pulse
    assert property (@(posedge clk) disable iff (rst) !(mem_rd && done))
        else $error("mem_rd and done high in the same cycle");

    // done drops again on the next cen cycle
    assert property (@(posedge clk) disable iff (rst) (done && cen) |=> !done)
        else $error("done held for more than one cen cycle");

    // leaving finish raises done with the sequencer already idle
    assert property (@(posedge clk) disable iff (rst)
                     (state == finish && cen) |=> (done && !busy))
        else $error("done missing or busy still high after finish");

endmodule

bind idx_sequencer idx_unit_assertions seq_checks_inst (
    .clk(clk), .rst(rst), .cen(cen), .state(state), .mem_rd(mem_rd),
    .busy(busy), .done(done)
);

// ==== tb/idx_unit_tb.sv ====
/*
  table driven testbench for idx_unit, the memory model answers mem_rd one clock later
  cen drops about one cycle in four, each start is repeated with another pc while busy
*/
`timescale 1ns/1ps

module idx_unit_tb;
    import idx_bus_pkg::*;
    import idx_mode_pkg::*;

    localparam int n_rows = 24;

    // one test: preloads, bytes placed in memory, expected results
    typedef struct packed {
        logic [7:0]  a, b;
        logic [15:0] x, y, u, s;
        logic [15:0] start_pc;
        logic [7:0]  pb;
        // bytes after the postbyte, the first one in bits 15:8
        logic [15:0] ofs;
        // indirect word and its address, written only when pb bit 3 is set
        logic [15:0] ind_addr;
        logic [15:0] ind_word;
        logic [15:0] exp_ea;
        // selected index register after writeback
        logic [15:0] exp_reg;
    } row_t;

    logic              clk, rst, cen, start;
    logic [addr_w-1:0] pc, mem_addr, reg_wdata, reg_rdata, ea;
    logic              mem_rd, reg_wr, done, busy;
    logic [data_w-1:0] mem_rdata;
    reg_sel_t          reg_sel;

    logic [data_w-1:0] mem [0:65535];
    row_t              rows [0:n_rows-1];
    int                n_added, passed, failed, errors;
    logic [31:0]       rng_state;

    idx_unit idx_unit_inst (
        .clk(clk), .rst(rst), .cen(cen), .start(start), .pc(pc),
        .mem_addr(mem_addr), .mem_rd(mem_rd), .mem_rdata(mem_rdata),
        .reg_wr(reg_wr), .reg_sel(reg_sel), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .ea(ea), .done(done), .busy(busy)
    );

    // --------------------------------------------------
    // clock, memory model, cen pattern
    // --------------------------------------------------
    always #4 clk = ~clk;

    // read data shows up on the clock after the strobe
    always @(posedge clk) begin
        if (mem_rd)
            mem_rdata <= mem[mem_addr];
    end

    function automatic logic [31:0] xorshift(input logic [31:0] v);
        logic [31:0] x;
        x = v;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // low when the two low bits are zero, so roughly one cycle in four
    always @(posedge clk) begin
        rng_state = xorshift(rng_state);
        cen <= (rng_state[1:0] != 2'b00);
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    // register port select for the index field, bits 6:5
    function automatic reg_sel_t index_sel(input logic [7:0] pb);
        case (pb[6:5])
            2'd0:    return sel_x;
            2'd1:    return sel_y;
            2'd2:    return sel_u;
            default: return sel_s;
        endcase
    endfunction

    task automatic add_row(input logic [7:0] a, b, input logic [15:0] x, y, u, s,
                           input logic [15:0] pc_v, input logic [7:0] pb,
                           input logic [15:0] ofs, ia, iw, ea_v, reg_v);
        rows[n_added] = {a, b, x, y, u, s, pc_v, pb, ofs, ia, iw, ea_v, reg_v};
        n_added++;
    endtask

    task automatic write_reg(input reg_sel_t sel, input logic [15:0] val);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_sel   <= sel;
        reg_wdata <= val;
    endtask

    task automatic run_test(input int t);
        row_t r;
        int   wait_cnt;
        logic ok;
        r  = rows[t];
        ok = 1'b1;
        mem[r.start_pc]         = r.pb;
        mem[r.start_pc + 16'd1] = r.ofs[15:8];
        mem[r.start_pc + 16'd2] = r.ofs[7:0];
        if (r.pb[pb_ind_bit]) begin
            mem[r.ind_addr]         = r.ind_word[15:8];
            mem[r.ind_addr + 16'd1] = r.ind_word[7:0];
        end
        write_reg(sel_a, {8'h00, r.a});
        write_reg(sel_b, {8'h00, r.b});
        write_reg(sel_x, r.x);
        write_reg(sel_y, r.y);
        write_reg(sel_u, r.u);
        write_reg(sel_s, r.s);
        @(posedge clk);
        reg_wr <= 1'b0;
        pc     <= r.start_pc;
        start  <= 1'b1;
        // start only counts on a cen cycle, hold it until busy rises
        wait_cnt = 0;
        @(negedge clk);
        while (!busy && wait_cnt < 40) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!busy) begin
            $display("test %0d: start was never accepted, busy stayed low", t);
            ok = 1'b0;
        end
        // second request while busy, must leave this run untouched
        @(posedge clk);
        pc <= ~r.start_pc;
        @(posedge clk);
        start <= 1'b0;
        wait_cnt = 0;
        @(negedge clk);
        while (!done && wait_cnt < 80) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!done) begin
            $display("test %0d: done never came", t);
            ok = 1'b0;
        end else if (ea !== r.exp_ea) begin
            $display("ERROR test %0d: ea = %h, expected %h", t, ea, r.exp_ea);
            ok = 1'b0;
        end
        // read back the index register named by the postbyte
        @(posedge clk);
        reg_sel <= index_sel(r.pb);
        @(negedge clk);
        if (reg_rdata !== r.exp_reg) begin
            $display("ERROR test %0d: reg_rdata = %h, expected %h", t, reg_rdata, r.exp_reg);
            ok = 1'b0;
        end
        if (ok)
            passed++;
        else
            failed++;
        $display("test %0d pb %h ea %h: %s", t, r.pb, ea, ok ? "ok" : "FAILED");
    endtask

    // --------------------------------------------------
    // test table
    // --------------------------------------------------
    // A, B, X, Y, U, S, then pc, postbyte, offset, ind addr, ind word, ea, index reg
    task automatic build_table();
        // constant offset modes, including wrap at 0000 and FFFF
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0100, 'h04, 'h0000, 'h0000, 'h0000, 'h1000, 'h1000);
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0108, 'h20, 'h0000, 'h0000, 'h0000, 'h2000, 'h2001);
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0110, 'h41, 'h0000, 'h0000, 'h0000, 'h3000, 'h3002);
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0118, 'h62, 'h0000, 'h0000, 'h0000, 'h3FFF, 'h3FFF);
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0120, 'h03, 'h0000, 'h0000, 'h0000, 'h0FFE, 'h0FFE);
        add_row('h12, 'h34, 'hFFFF, 'h2000, 'h3000, 'h4000,
                'h0128, 'h00, 'h0000, 'h0000, 'h0000, 'hFFFF, 'h0000);
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'hFFFF,
                'h0130, 'h61, 'h0000, 'h0000, 'h0000, 'hFFFF, 'h0001);
        add_row('h12, 'h34, 'h1000, 'h2000, 'h0000, 'h4000,
                'h0138, 'h42, 'h0000, 'h0000, 'h0000, 'hFFFF, 'hFFFF);
        add_row('h12, 'h34, 'h1000, 'h0001, 'h3000, 'h4000,
                'h0140, 'h23, 'h0000, 'h0000, 'h0000, 'hFFFF, 'hFFFF);
        // accumulator offsets, A and B sign extended, D taken as is
        add_row('hF0, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0148, 'h06, 'h0000, 'h0000, 'h0000, 'h0FF0, 'h1000);
        add_row('h7F, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0150, 'h26, 'h0000, 'h0000, 'h0000, 'h207F, 'h2000);
        add_row('h12, 'h80, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0158, 'h45, 'h0000, 'h0000, 'h0000, 'h2F80, 'h3000);
        add_row('h12, 'h05, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0160, 'h65, 'h0000, 'h0000, 'h0000, 'h4005, 'h4000);
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0168, 'h83, 'h0000, 'h0000, 'h0000, 'h2234, 'h1000);
        add_row('hF0, 'h00, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0170, 'hA3, 'h0000, 'h0000, 'h0000, 'h1000, 'h2000);
        // displacements, pc relative base is the address after the last offset byte
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0178, 'h80, 'hFE00, 'h0000, 'h0000, 'h0FFE, 'h1000);
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0180, 'hE1, 'h1234, 'h0000, 'h0000, 'h5234, 'h4000);
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0200, 'h84, 'h1000, 'h0000, 'h0000, 'h0212, 'h1000);
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0210, 'h85, 'h1000, 'h0000, 'h0000, 'h1213, 'h1000);
        // extended, then indirect through off16 and inc2
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0220, 'h87, 'hC000, 'h0000, 'h0000, 'hC000, 'h1000);
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0228, 'h89, 'h0200, 'h1200, 'hBEEF, 'hBEEF, 'h1000);
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0230, 'h49, 'h0000, 'h3000, 'h1357, 'h1357, 'h3002);
        // undefined codes behave as zero offset
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0238, 'h27, 'h0000, 'h0000, 'h0000, 'h2000, 'h2000);
        add_row('h12, 'h34, 'h1000, 'h2000, 'h3000, 'h4000,
                'h0240, 'hE2, 'h0000, 'h0000, 'h0000, 'h4000, 'h4000);
    endtask

    // --------------------------------------------------
    // watchdog and main sequence
    // --------------------------------------------------
    // 40 cycles per row, doubled for cen gaps, plus reset
    initial begin
        repeat (n_rows * 40 * 2 + 8) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Verification failed");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        cen       = 1'b0;
        start     = 1'b0;
        pc        = '0;
        mem_rdata = '0;
        reg_wr    = 1'b0;
        reg_sel   = sel_a;
        reg_wdata = '0;
        rng_state = 32'd92;
        n_added   = 0;
        passed    = 0;
        failed    = 0;
        errors    = 0;
        // fill pattern from both address bytes
        for (int i = 0; i < 65536; i++)
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
        build_table();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b0 || done !== 1'b0 || mem_rd !== 1'b0) begin
            $display("ERROR reset: busy = %h, done = %h, mem_rd = %h, expected 0",
                     busy, done, mem_rd);
            errors++;
        end
        if (reg_rdata !== 16'h0000) begin
            $display("ERROR reset: reg_rdata = %h, expected 0000", reg_rdata);
            errors++;
        end
        for (int t = 0; t < n_rows; t++)
            run_test(t);
        $display("tests %0d, passed %0d, failed %0d, reset errors %0d",
                 n_rows, passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
